/* files.f */
+incdir+include
src/bp_pkg.sv
src/pht.sv
src/btb.sv
src/history_tables.sv
src/perf_counters.sv
src/bp_control.sv
src/branch_predictor.sv
tests/bp_assertions.sv
tests/tb_branch_predictor.sv

/* include/bp_defs.svh */
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// address width
`define XLEN 32

// bits of global and local history, also the index width of both pattern tables
`define HISTORY_DEPTH 4

// local history table index width
`define BHT_INDEX_BITS 4

// direct-mapped target buffer index width
`define BTB_INDEX_BITS 4

// tournament chooser table index width
`define CHOOSER_INDEX_BITS 5

// performance counter width
`define PERF_WIDTH 16

`endif

/* src/bp_control.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module bp_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      lookup_valid,
    input  logic [`XLEN-1:0]          lookup_pc,
    input  logic                      update_valid,
    input  bp_pkg::bp_update_t        update,
    input  logic                      btb_hit,
    input  bp_pkg::btb_entry_t        btb_rd_entry,
    input  logic [`HISTORY_DEPTH-1:0] ghr,
    input  logic [`HISTORY_DEPTH-1:0] local_hist,
    input  bp_pkg::sat_ctr_e          global_ctr,
    input  bp_pkg::sat_ctr_e          local_ctr,
    input  bp_pkg::sat_ctr_e          chooser_ctr,
    output logic                      pred_valid,
    output bp_pkg::prediction_t       pred,
    output logic                      btb_we,
    output bp_pkg::btb_entry_t        btb_wr_entry,
    output logic                      ghr_shift,
    output logic                      bht_shift,
    output logic                      global_inc,
    output logic                      global_dec,
    output logic                      local_inc,
    output logic                      local_dec,
    output logic                      chooser_inc,
    output logic                      chooser_dec,
    output logic [`HISTORY_DEPTH-1:0] global_windex,
    output logic [`HISTORY_DEPTH-1:0] local_windex,
    output logic                      count_cf,
    output logic                      count_correct,
    output logic                      count_no_redirect
);

    bp_pkg::prediction_t pred_next;
    logic                global_pred;
    logic                local_pred;
    logic                dir_pred;
    logic                is_br;
    logic                is_jalr;
    logic                dir_right;
    logic                global_right;
    logic                local_right;
    logic                target_wrong;
    logic [`XLEN-1:0]    resolved_target;

    function automatic logic ctr_taken(bp_pkg::sat_ctr_e s);
        return (s == bp_pkg::weak_t) || (s == bp_pkg::strong_t);
    endfunction

    assign global_pred = ctr_taken(global_ctr);
    assign local_pred  = ctr_taken(local_ctr);
    assign dir_pred    = ctr_taken(chooser_ctr) ? global_pred : local_pred;   // tournament pick

    always_comb begin
        pred_next.hit    = btb_hit;
        pred_next.taken  = btb_hit && (btb_rd_entry.kind != bp_pkg::cf_br || dir_pred);
        pred_next.target = pred_next.taken ? btb_rd_entry.target : lookup_pc + 'd4;
        pred_next.meta.ghist       = ghr;
        pred_next.meta.lhist       = local_hist;
        pred_next.meta.local_pred  = local_pred;
        pred_next.meta.global_pred = global_pred;
        pred_next.meta.final_pred  = pred_next.taken;
        pred_next.meta.hit         = btb_hit;
        pred_next.meta.btb_target  = btb_hit ? btb_rd_entry.target : '0;   // invalid rows may hold x
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        pred <= pred_next;   // payload only
    end

    // resolution side
    always_comb begin
        is_br   = 1'b0;
        is_jalr = 1'b0;
        case (update.kind)
            bp_pkg::cf_br:   is_br = 1'b1;
            bp_pkg::cf_jalr: is_jalr = 1'b1;
            default: ;
        endcase
    end

    assign resolved_target = is_jalr ? {update.target[`XLEN-1:1], 1'b0} : update.target;
    assign target_wrong    = resolved_target != update.meta.btb_target;
    assign dir_right       = update.taken == update.meta.final_pred;
    assign global_right    = update.taken == update.meta.global_pred;
    assign local_right     = update.taken == update.meta.local_pred;

    // pattern tables train only on branches
    assign global_inc    = update_valid && is_br && update.taken;
    assign global_dec    = update_valid && is_br && !update.taken;
    assign local_inc     = update_valid && is_br && update.taken;
    assign local_dec     = update_valid && is_br && !update.taken;
    assign global_windex = update.meta.ghist;
    assign local_windex  = update.meta.lhist;

    // chooser moves only when the two disagree in correctness
    assign chooser_inc = update_valid && is_br && global_right && !local_right;
    assign chooser_dec = update_valid && is_br && local_right && !global_right;

    assign ghr_shift = update_valid && is_br;
    assign bht_shift = update_valid && is_br;

    assign btb_we              = update_valid && (!is_br || update.taken);
    assign btb_wr_entry.tag    = update.pc[`XLEN-1:`BTB_INDEX_BITS+2];
    assign btb_wr_entry.target = resolved_target;
    assign btb_wr_entry.kind   = update.kind;

    assign count_cf      = update_valid;
    assign count_correct = update_valid && is_br && dir_right;

    always_comb begin
        count_no_redirect = 1'b0;
        if (update_valid) begin
            if (is_br) begin
                count_no_redirect = (update.meta.hit && dir_right && !target_wrong) ||
                                    (!update.meta.hit && !update.taken);
            end else begin
                count_no_redirect = update.meta.hit && !target_wrong;   // jal / jalr
            end
        end
    end

endmodule : bp_control

/* src/bp_pkg.sv */
`include "bp_defs.svh"

package bp_pkg;

    // control-flow kind as stored in the BTB
    typedef enum logic [1:0] {
        cf_br   = 2'b00,
        cf_jal  = 2'b01,
        cf_jalr = 2'b10
    } cf_kind_e;

    // two-bit saturating counter, upper half means taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } sat_ctr_e;

    typedef struct packed {
        logic [`XLEN-`BTB_INDEX_BITS-3:0] tag;    // pc bits above the index
        logic [`XLEN-1:0]                 target;
        cf_kind_e                         kind;
    } btb_entry_t;

    // captured at lookup, handed back with the update
    typedef struct packed {
        logic [`HISTORY_DEPTH-1:0] ghist;       // global pht index used
        logic [`HISTORY_DEPTH-1:0] lhist;       // local pht index used
        logic                      local_pred;
        logic                      global_pred;
        logic                      final_pred;  // direction sent to fetch
        logic                      hit;
        logic [`XLEN-1:0]          btb_target;  // zero on a miss
    } pred_meta_t;

    typedef struct packed {
        logic             hit;
        logic             taken;
        logic [`XLEN-1:0] target;
        pred_meta_t       meta;
    } prediction_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             taken;
        logic [`XLEN-1:0] target;   // resolved target
        cf_kind_e         kind;
        pred_meta_t       meta;
    } bp_update_t;

    typedef struct packed {
        logic [`PERF_WIDTH-1:0] cf_count;
        logic [`PERF_WIDTH-1:0] correct_count;
        logic [`PERF_WIDTH-1:0] no_redirect_count;
        logic                   cf_overflow;
        logic                   correct_overflow;
        logic                   no_redirect_overflow;
    } perf_counts_t;

endpackage

/* src/branch_predictor.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup_valid,
    input  logic [`XLEN-1:0]     lookup_pc,
    input  logic                 update_valid,
    input  bp_pkg::bp_update_t   update,
    output logic                 pred_valid,
    output bp_pkg::prediction_t  pred,
    output bp_pkg::perf_counts_t perf
);

    logic                      btb_hit;
    bp_pkg::btb_entry_t        btb_rd_entry;
    logic                      btb_we;
    bp_pkg::btb_entry_t        btb_wr_entry;
    logic [`HISTORY_DEPTH-1:0] ghr;
    logic [`HISTORY_DEPTH-1:0] local_hist;
    logic                      ghr_shift;
    logic                      bht_shift;
    bp_pkg::sat_ctr_e          global_ctr;
    bp_pkg::sat_ctr_e          local_ctr;
    bp_pkg::sat_ctr_e          chooser_ctr;
    logic                      global_inc;
    logic                      global_dec;
    logic                      local_inc;
    logic                      local_dec;
    logic                      chooser_inc;
    logic                      chooser_dec;
    logic [`HISTORY_DEPTH-1:0] global_windex;
    logic [`HISTORY_DEPTH-1:0] local_windex;
    logic                      count_cf;
    logic                      count_correct;
    logic                      count_no_redirect;

    bp_control bp_control (
        .clk(clk),
        .rst(rst),
        .lookup_valid(lookup_valid),
        .lookup_pc(lookup_pc),
        .update_valid(update_valid),
        .update(update),
        .btb_hit(btb_hit),
        .btb_rd_entry(btb_rd_entry),
        .ghr(ghr),
        .local_hist(local_hist),
        .global_ctr(global_ctr),
        .local_ctr(local_ctr),
        .chooser_ctr(chooser_ctr),
        .pred_valid(pred_valid),
        .pred(pred),
        .btb_we(btb_we),
        .btb_wr_entry(btb_wr_entry),
        .ghr_shift(ghr_shift),
        .bht_shift(bht_shift),
        .global_inc(global_inc),
        .global_dec(global_dec),
        .local_inc(local_inc),
        .local_dec(local_dec),
        .chooser_inc(chooser_inc),
        .chooser_dec(chooser_dec),
        .global_windex(global_windex),
        .local_windex(local_windex),
        .count_cf(count_cf),
        .count_correct(count_correct),
        .count_no_redirect(count_no_redirect)
    );

    btb btb (
        .clk(clk),
        .rst(rst),
        .rd_pc(lookup_pc),
        .wr_pc(update.pc),
        .we(btb_we),
        .wr_entry(btb_wr_entry),
        .hit(btb_hit),
        .rd_entry(btb_rd_entry)
    );

    history_tables history_tables (
        .clk(clk),
        .rst(rst),
        .rd_pc(lookup_pc),
        .wr_pc(update.pc),
        .ghr_shift(ghr_shift),
        .bht_shift(bht_shift),
        .taken(update.taken),
        .ghr(ghr),
        .local_hist(local_hist)
    );

    pht #(.INDEX_BITS(`HISTORY_DEPTH)) global_pht (
        .clk(clk),
        .rst(rst),
        .rindex(ghr),
        .windex(global_windex),
        .inc(global_inc),
        .dec(global_dec),
        .state(global_ctr)
    );

    pht #(.INDEX_BITS(`HISTORY_DEPTH)) local_pht (
        .clk(clk),
        .rst(rst),
        .rindex(local_hist),
        .windex(local_windex),
        .inc(local_inc),
        .dec(local_dec),
        .state(local_ctr)
    );

    pht #(.INDEX_BITS(`CHOOSER_INDEX_BITS)) chooser_pht (
        .clk(clk),
        .rst(rst),
        .rindex(lookup_pc[`CHOOSER_INDEX_BITS+1:2]),
        .windex(update.pc[`CHOOSER_INDEX_BITS+1:2]),
        .inc(chooser_inc),
        .dec(chooser_dec),
        .state(chooser_ctr)
    );

    perf_counters perf_counters (
        .clk(clk),
        .rst(rst),
        .count_cf(count_cf),
        .count_correct(count_correct),
        .count_no_redirect(count_no_redirect),
        .perf(perf)
    );

endmodule : branch_predictor

/* src/btb.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module btb (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   rd_pc,
    input  logic [`XLEN-1:0]   wr_pc,
    input  logic               we,
    input  bp_pkg::btb_entry_t wr_entry,
    output logic               hit,
    output bp_pkg::btb_entry_t rd_entry
);

    localparam int ENTRIES = 2 ** `BTB_INDEX_BITS;

    bp_pkg::btb_entry_t         entries [ENTRIES];
    logic [ENTRIES-1:0]         valid;
    logic [`BTB_INDEX_BITS-1:0] rd_idx;
    logic [`BTB_INDEX_BITS-1:0] wr_idx;

    assign rd_idx = rd_pc[`BTB_INDEX_BITS+1:2];
    assign wr_idx = wr_pc[`BTB_INDEX_BITS+1:2];

    assign rd_entry = entries[rd_idx];
    assign hit      = valid[rd_idx] && (entries[rd_idx].tag == rd_pc[`XLEN-1:`BTB_INDEX_BITS+2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (we) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entries[wr_idx] <= wr_entry;   // overwrites any alias
        end
    end

endmodule : btb

/* src/history_tables.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module history_tables (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`XLEN-1:0]          rd_pc,
    input  logic [`XLEN-1:0]          wr_pc,
    input  logic                      ghr_shift,
    input  logic                      bht_shift,
    input  logic                      taken,
    output logic [`HISTORY_DEPTH-1:0] ghr,
    output logic [`HISTORY_DEPTH-1:0] local_hist
);

    localparam int ENTRIES = 2 ** `BHT_INDEX_BITS;

    logic [`HISTORY_DEPTH-1:0]  bht [ENTRIES];
    logic [`BHT_INDEX_BITS-1:0] rd_idx;
    logic [`BHT_INDEX_BITS-1:0] wr_idx;

    assign rd_idx     = rd_pc[`BHT_INDEX_BITS+1:2];
    assign wr_idx     = wr_pc[`BHT_INDEX_BITS+1:2];
    assign local_hist = bht[rd_idx];

    // newest outcome in bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (ghr_shift) begin
            ghr <= {ghr[`HISTORY_DEPTH-2:0], taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                bht[i] <= '0;
            end
        end else if (bht_shift) begin
            bht[wr_idx] <= {bht[wr_idx][`HISTORY_DEPTH-2:0], taken};
        end
    end

endmodule : history_tables

/* src/perf_counters.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module perf_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 count_cf,
    input  logic                 count_correct,
    input  logic                 count_no_redirect,
    output bp_pkg::perf_counts_t perf
);

    logic [2:0]             strobe;
    logic [`PERF_WIDTH-1:0] count [3];
    logic [2:0]             overflow;

    assign strobe = {count_no_redirect, count_correct, count_cf};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                count[i] <= '0;
            end
            overflow <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (strobe[i]) begin
                    count[i] <= count[i] + 1'b1;   // wraps to zero
                    if (&count[i]) begin
                        overflow[i] <= 1'b1;   // sticky
                    end
                end
            end
        end
    end

    assign perf.cf_count             = count[0];
    assign perf.correct_count        = count[1];
    assign perf.no_redirect_count    = count[2];
    assign perf.cf_overflow          = overflow[0];
    assign perf.correct_overflow     = overflow[1];
    assign perf.no_redirect_overflow = overflow[2];

endmodule : perf_counters

/* src/pht.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module pht #(
    parameter int INDEX_BITS = `HISTORY_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] rindex,
    input  logic [INDEX_BITS-1:0] windex,
    input  logic                  inc,
    input  logic                  dec,
    output bp_pkg::sat_ctr_e      state
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    bp_pkg::sat_ctr_e ctrs [ENTRIES];

    assign state = ctrs[rindex];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctrs[i] <= bp_pkg::weak_nt;   // start just below taken
            end
        end else if (inc && ctrs[windex] != bp_pkg::strong_t) begin
            ctrs[windex] <= bp_pkg::sat_ctr_e'(ctrs[windex] + 2'd1);
        end else if (dec && ctrs[windex] != bp_pkg::strong_nt) begin
            ctrs[windex] <= bp_pkg::sat_ctr_e'(ctrs[windex] - 2'd1);
        end
    end

endmodule : pht

/* tests/bp_assertions.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module bp_assertions (
    input logic                clk,
    input logic                rst,
    input logic                lookup_valid,
    input logic                pred_valid,
    input bp_pkg::prediction_t pred
);

    // fixed one-cycle latency, every lookup answered
    property valid_follows_lookup;
        @(posedge clk) disable iff (rst)
            pred_valid == $past(lookup_valid);
    endproperty

    property quiet_in_reset;
        @(posedge clk) rst |=> !pred_valid;
    endproperty

    property known_when_valid;
        @(posedge clk) disable iff (rst)
            pred_valid |-> !$isunknown(pred);
    endproperty

    // a taken prediction needs a target from the BTB
    property taken_needs_hit;
        @(posedge clk) disable iff (rst)
            (pred_valid && pred.taken) |-> pred.hit;
    endproperty

    a_valid_follows_lookup: assert property (valid_follows_lookup)
        else $error("pred_valid does not follow lookup_valid by one cycle");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("pred_valid high during reset");
    a_known_when_valid: assert property (known_when_valid)
        else $error("prediction holds x or z while valid");
    a_taken_needs_hit: assert property (taken_needs_hit)
        else $error("prediction taken without a BTB hit");

endmodule : bp_assertions

bind branch_predictor bp_assertions bp_assertions_inst (
    .clk(clk),
    .rst(rst),
    .lookup_valid(lookup_valid),
    .pred_valid(pred_valid),
    .pred(pred)
);

/* tests/tb_branch_predictor.sv */
`timescale 1ns/100ps
`include "bp_defs.svh"

module tb_branch_predictor;

    localparam int TIMEOUT_CYCLES = 20;

    // update rows check the lookup issued just before the update
    typedef struct packed {
        logic             is_update;
        logic [`XLEN-1:0] pc;
        bp_pkg::cf_kind_e kind;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic             exp_hit;
        logic             exp_taken;
        logic [`XLEN-1:0] exp_target;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic                 lookup_valid;
    logic [`XLEN-1:0]     lookup_pc;
    logic                 update_valid;
    bp_pkg::bp_update_t   update;
    logic                 pred_valid;
    bp_pkg::prediction_t  pred;
    bp_pkg::perf_counts_t perf;

    row_t   rows[$];
    int     errors;
    int     checks;
    int     tests;
    int     exp_cf;
    int     exp_correct;
    int     exp_no_redirect;
    bit     timed_out;
    integer seed;

    branch_predictor branch_predictor_inst (
        .clk(clk),
        .rst(rst),
        .lookup_valid(lookup_valid),
        .lookup_pc(lookup_pc),
        .update_valid(update_valid),
        .update(update),
        .pred_valid(pred_valid),
        .pred(pred),
        .perf(perf)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic void add_row(input logic is_update, input logic [`XLEN-1:0] pc,
            input bp_pkg::cf_kind_e kind, input logic taken, input logic [`XLEN-1:0] target,
            input logic exp_hit, input logic exp_taken, input logic [`XLEN-1:0] exp_target);
        rows.push_back(row_t'{is_update, pc, kind, taken, target, exp_hit, exp_taken,
                              exp_target});
    endfunction

    task automatic build_table();
        add_row(0, 32'h0000_1000, bp_pkg::cf_br,   0, 32'h0,         0, 0, 32'h0000_1004);
        add_row(0, 32'h8000_0040, bp_pkg::cf_br,   0, 32'h0,         0, 0, 32'h8000_0044);
        add_row(1, 32'h0000_1000, bp_pkg::cf_jal,  1, 32'h0000_2000, 0, 0, 32'h0000_1004);
        add_row(0, 32'h0000_1000, bp_pkg::cf_jal,  0, 32'h0,         1, 1, 32'h0000_2000);
        add_row(1, 32'h0000_1000, bp_pkg::cf_jal,  1, 32'h0000_2000, 1, 1, 32'h0000_2000);
        add_row(1, 32'h0000_1104, bp_pkg::cf_jalr, 1, 32'h0000_3003, 0, 0, 32'h0000_1108);
        add_row(0, 32'h0000_1104, bp_pkg::cf_jalr, 0, 32'h0,         1, 1, 32'h0000_3002);
        add_row(1, 32'h0000_1104, bp_pkg::cf_jalr, 1, 32'h0000_3003, 1, 1, 32'h0000_3002);
        add_row(1, 32'h0000_1208, bp_pkg::cf_br,   0, 32'h0000_1300, 0, 0, 32'h0000_120c);
        add_row(0, 32'h0000_1208, bp_pkg::cf_br,   0, 32'h0,         0, 0, 32'h0000_120c);
        // always-taken branch, local history walks 0 -> 1 -> 3 -> 7 -> f
        add_row(1, 32'h0000_130c, bp_pkg::cf_br,   1, 32'h0000_1400, 0, 0, 32'h0000_1310);
        for (int r = 0; r < `HISTORY_DEPTH; r++) begin
            add_row(1, 32'h0000_130c, bp_pkg::cf_br, 1, 32'h0000_1400, 1, 0, 32'h0000_1310);
        end
        add_row(1, 32'h0000_130c, bp_pkg::cf_br,   1, 32'h0000_1400, 1, 1, 32'h0000_1400);
        add_row(1, 32'h0000_130c, bp_pkg::cf_br,   1, 32'h0000_1400, 1, 1, 32'h0000_1400);
        add_row(0, 32'h0000_130c, bp_pkg::cf_br,   0, 32'h0,         1, 1, 32'h0000_1400);
    endtask

    // expected strobes from the resolution rules
    function automatic void tally_counts(input row_t r);
        logic [`XLEN-1:0] resolved;
        logic             dir_ok;
        resolved = (r.kind == bp_pkg::cf_jalr) ? (r.target & ~32'd1) : r.target;
        dir_ok   = (r.taken == r.exp_taken);
        exp_cf++;
        if (r.kind == bp_pkg::cf_br) begin
            if (dir_ok) begin
                exp_correct++;
            end
            if ((r.exp_hit && dir_ok && resolved == r.exp_target) || (!r.exp_hit && !r.taken)) begin
                exp_no_redirect++;
            end
        end else if (r.exp_hit && resolved == r.exp_target) begin
            exp_no_redirect++;
        end
    endfunction

    task automatic issue_lookup(input logic [`XLEN-1:0] pc, output bp_pkg::prediction_t p);
        int waited;
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        @(posedge clk);
        lookup_valid <= 1'b0;
        waited = 0;
        @(negedge clk);   // sample away from the edge
        while (pred_valid !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (pred_valid !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: no prediction for pc %h within %0d cycles", pc, TIMEOUT_CYCLES);
        end
        p = pred;
    endtask

    task automatic send_update(input row_t r, input bp_pkg::pred_meta_t meta);
        bp_pkg::bp_update_t u;
        u.pc     = r.pc;
        u.taken  = r.taken;
        u.target = r.target;
        u.kind   = r.kind;
        u.meta   = meta;   // snapshot from the lookup before
        @(posedge clk);
        update_valid <= 1'b1;
        update       <= u;
        @(posedge clk);
        update_valid <= 1'b0;
    endtask

    task automatic check_prediction(input bp_pkg::prediction_t p, input logic exp_hit,
                                    input logic exp_taken, input logic [`XLEN-1:0] exp_target);
        check_value("pred.hit", p.hit, exp_hit);
        check_value("pred.taken", p.taken, exp_taken);
        check_value("pred.target", p.target, exp_target);
    endtask

    initial begin
        bp_pkg::prediction_t p;
        logic [`XLEN-1:0]    rand_pc;
        int                  row_errors;
        int                  i;
        clk          = 1'b0;
        rst          = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        update_valid = 1'b0;
        update       = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        exp_cf       = 0;
        exp_correct  = 0;
        exp_no_redirect = 0;
        timed_out    = 1'b0;
        seed         = 5447;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        row_errors = errors;
        check_value("cf_count after reset", perf.cf_count, '0);
        check_value("correct_count after reset", perf.correct_count, '0);
        check_value("no_redirect_count after reset", perf.no_redirect_count, '0);
        for (i = 0; i < 4 && !timed_out; i++) begin
            rand_pc      = $random(seed);
            rand_pc[1:0] = 2'b00;
            issue_lookup(rand_pc, p);
            check_prediction(p, 1'b0, 1'b0, rand_pc + 32'd4);   // empty BTB
        end
        tests++;
        $display("test reset state: %s", (errors == row_errors) ? "ok" : "mismatch");

        for (i = 0; i < rows.size() && !timed_out; i++) begin
            row_errors = errors;
            issue_lookup(rows[i].pc, p);
            check_prediction(p, rows[i].exp_hit, rows[i].exp_taken, rows[i].exp_target);
            if (rows[i].is_update) begin
                tally_counts(rows[i]);
                send_update(rows[i], p.meta);
            end
            tests++;
            $display("test %0d %s pc %h: %s", i, rows[i].is_update ? "update" : "lookup",
                     rows[i].pc, (errors == row_errors) ? "ok" : "mismatch");
        end

        @(negedge clk);
        row_errors = errors;
        check_value("cf_count", perf.cf_count, exp_cf);
        check_value("correct_count", perf.correct_count, exp_correct);
        check_value("no_redirect_count", perf.no_redirect_count, exp_no_redirect);
        check_value("cf_overflow", perf.cf_overflow, 1'b0);
        check_value("correct_overflow", perf.correct_overflow, 1'b0);
        check_value("no_redirect_overflow", perf.no_redirect_overflow, 1'b0);
        tests++;
        $display("test perf counters: %s", (errors == row_errors) ? "ok" : "mismatch");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_branch_predictor
